/* logic/ucpd_line_pkg.sv */
package ucpd_line_pkg;

  // ---------------------------------------------------------------------
  // line symbol geometry
  // ---------------------------------------------------------------------
  localparam int sym_w = 5;  // bits per 4b5b symbol

  // bit 0 of each code is the first bit taken from the line
  localparam logic [sym_w-1:0] sync_1 = 5'b11000;  // startsynch #1
  localparam logic [sym_w-1:0] sync_2 = 5'b10001;  // startsynch #2
  localparam logic [sym_w-1:0] sync_3 = 5'b00110;  // startsynch #3
  localparam logic [sym_w-1:0] rst_1  = 5'b00111;  // hard reset #1
  localparam logic [sym_w-1:0] rst_2  = 5'b11001;  // hard reset #2
  localparam logic [sym_w-1:0] eop_k  = 5'b01101;  // end of packet

  // ---------------------------------------------------------------------
  // named k-codes
  // ---------------------------------------------------------------------
  typedef enum logic [sym_w-1:0] {
    k_sync_1 = sync_1,
    k_sync_2 = sync_2,
    k_sync_3 = sync_3,
    k_rst_1  = rst_1,
    k_rst_2  = rst_2,
    k_eop    = eop_k
  } k_code_e;

  // one received symbol, read as k-code by control and
  // ordered-set logic, as raw 5b code by the data decoder
  typedef union packed {
    k_code_e          kcode;  // control symbol view
    logic [sym_w-1:0] raw;    // 4b5b data view
  } sym_u;

endpackage

/* logic/ucpd_rx_pkg.sv */
package ucpd_rx_pkg;

  // ---------------------------------------------------------------------
  // receiver sizes
  // ---------------------------------------------------------------------
  localparam int kslot_n   = 4;   // k-codes per ordered set
  localparam int paysize_w = 10;  // payload byte count width

  // detected ordered set, register encoding
  typedef enum logic [2:0] {
    sop       = 3'd0,
    sop_p     = 3'd1,
    sop_pp    = 3'd2,
    cable_rst = 3'd3
  } ordset_e;

  // ---------------------------------------------------------------------
  // reports towards software
  // ---------------------------------------------------------------------
  typedef struct packed {
    logic [2:0] kerr_num;       // 0 clean, 1..4 bad slot, 7 invalid
    logic       three_of_four;  // set found with one corrupted k-code
    ordset_e    det;            // last detected set type
  } ordset_info_t;

  typedef struct packed {
    logic msg_end;     // eop seen, pulse
    logic ovrflow;     // byte lost, pulse
    logic hrst_det;    // hard reset set, pulse
    logic ordset_vld;  // sop type set, pulse
    logic rxne;        // rxdr holds an unread byte
  } rx_status_t;

endpackage

/* logic/symbol_shifter.sv */
`timescale 1ns/10ps

module symbol_shifter (
  input  logic                ucpd_clk,
  input  logic                ic_rst_n,
  input  logic                rx_idle_en,
  input  logic                rx_sop_en,
  input  logic                rx_data_en,
  input  logic                rx_bit_sample,  // decode_bmc valid this cycle
  input  logic                decode_bmc,
  output ucpd_line_pkg::sym_u sym,
  output logic                sym_vld         // sym just completed
);

  logic [ucpd_line_pkg::sym_w-2:0] sh;   // first four bits with the oldest at lsb
  logic [2:0]                      cnt;  // bits in sh
  logic                            take;
  logic                            last;

  assign take = rx_bit_sample & (rx_sop_en | rx_data_en);
  assign last = (cnt == 3'(ucpd_line_pkg::sym_w - 1));

  always_ff @(posedge ucpd_clk or negedge ic_rst_n)
  begin
    if (!ic_rst_n)
    begin
      sh      <= '0;
      cnt     <= 3'd0;
      sym_vld <= 1'b0;
    end
    else if (rx_idle_en)
    begin
      sh      <= '0;
      cnt     <= 3'd0;
      sym_vld <= 1'b0;
    end
    else
    begin
      sym_vld <= take & last;
      if (take)
      begin
        sh  <= {decode_bmc, sh[ucpd_line_pkg::sym_w-2:1]};
        cnt <= last ? 3'd0 : cnt + 3'd1;  // wrap after fifth bit
      end
    end
  end

  // held until the next symbol completes
  always_ff @(posedge ucpd_clk)
  begin
    if (take & last)
      sym.raw <= {decode_bmc, sh};
  end

endmodule

/* logic/rx_phase_ctrl.sv */
`timescale 1ns/10ps

module rx_phase_ctrl (
  input  logic                ucpd_clk,
  input  logic                ic_rst_n,
  input  logic                rx_idle_en,
  input  logic                rx_sop_en,
  input  logic                rx_data_en,
  input  ucpd_line_pkg::sym_u sym,
  input  logic                sym_vld,
  output logic                kslot_wr,     // store sym into a k-code slot
  output logic [1:0]          kslot_idx,
  output logic                ordset_eval,  // all slots filled, check set
  output logic                nib_wr,       // data symbol to the decoder
  output logic                nib_hi,       // 0 low nibble, 1 high nibble
  output logic                sop_start,    // rising edge of rx_sop_en
  output logic                msg_end
);

  logic       sop_d;   // phase when the symbol's last bit came in
  logic       data_d;
  logic [2:0] kcnt;    // slots filled so far, stops at kslot_n
  logic       hi_q;    // next data symbol is a high nibble
  logic       is_eop;

  // ---------------------------------------------------------------------
  // per-symbol strobes, all in the sym_vld cycle
  // ---------------------------------------------------------------------
  assign is_eop    = (sym.kcode == ucpd_line_pkg::k_eop);
  assign sop_start = rx_sop_en & ~sop_d;
  assign kslot_wr  = sym_vld & sop_d & (kcnt < 3'(ucpd_rx_pkg::kslot_n));
  assign kslot_idx = kcnt[1:0];
  assign nib_wr    = sym_vld & data_d & ~is_eop;  // eop is not data
  assign nib_hi    = hi_q;

  // phase delay, sym_vld trails the last bit by one cycle
  always_ff @(posedge ucpd_clk or negedge ic_rst_n)
  begin
    if (!ic_rst_n)
    begin
      sop_d  <= 1'b0;
      data_d <= 1'b0;
    end
    else
    begin
      sop_d  <= rx_sop_en;
      data_d <= rx_data_en;
    end
  end

  // ---------------------------------------------------------------------
  // slot counter, nibble order, end of packet
  // ---------------------------------------------------------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n)
  begin
    if (!ic_rst_n)
    begin
      kcnt        <= 3'd0;
      hi_q        <= 1'b0;
      ordset_eval <= 1'b0;
      msg_end     <= 1'b0;
    end
    else if (rx_idle_en)
    begin
      kcnt        <= 3'd0;  // ready for the next packet
      hi_q        <= 1'b0;
      ordset_eval <= 1'b0;
      msg_end     <= 1'b0;
    end
    else
    begin
      if (kslot_wr)
        kcnt <= kcnt + 3'd1;
      if (nib_wr)
        hi_q <= ~hi_q;  // low nibble first
      ordset_eval <= kslot_wr & (kslot_idx == 2'(ucpd_rx_pkg::kslot_n - 1));
      msg_end     <= sym_vld & data_d & is_eop;
    end
  end

endmodule

/* logic/ordset_detector.sv */
`timescale 1ns/10ps

module ordset_detector (
  input  logic                      ucpd_clk,
  input  logic                      ic_rst_n,
  input  logic                      rx_idle_en,
  input  ucpd_line_pkg::sym_u       sym,
  input  logic                      kslot_wr,
  input  logic [1:0]                kslot_idx,
  input  logic                      ordset_eval,
  output ucpd_rx_pkg::ordset_info_t rx_ordset,
  output logic                      ordset_vld,
  output logic                      hrst_det
);

  ucpd_line_pkg::k_code_e slot [ucpd_rx_pkg::kslot_n];  // slot 0 is first k-code
  logic [ucpd_rx_pkg::kslot_n-1:0] good_q;  // slot holds sync or rst code
  logic m_sop;     // per-type three-of-four hits
  logic m_sop_p;
  logic m_sop_pp;
  logic m_hrst;
  logic m_crst;
  logic eval_d;    // match stage valid
  logic os_hit;
  logic [2:0] kerr_nxt;
  ucpd_rx_pkg::ordset_e det_nxt;

  function automatic logic is_kcode(input ucpd_line_pkg::k_code_e k);
    case (k)
      ucpd_line_pkg::k_sync_1, ucpd_line_pkg::k_sync_2, ucpd_line_pkg::k_sync_3,
      ucpd_line_pkg::k_rst_1, ucpd_line_pkg::k_rst_2:
        is_kcode = 1'b1;
      default:
        is_kcode = 1'b0;  // eop or corrupted symbol
    endcase
  endfunction

  // any three positions equal to the pattern
  function automatic logic match3(input ucpd_line_pkg::k_code_e p0,
                                  input ucpd_line_pkg::k_code_e p1,
                                  input ucpd_line_pkg::k_code_e p2,
                                  input ucpd_line_pkg::k_code_e p3);
    logic [3:0] hit;
    hit    = {slot[3] == p3, slot[2] == p2, slot[1] == p1, slot[0] == p0};
    match3 = ($countones(hit) >= 3);
  endfunction

  // ---------------------------------------------------------------------
  // k-code slots
  // ---------------------------------------------------------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n)
  begin
    if (!ic_rst_n)
    begin
      for (int i = 0; i < ucpd_rx_pkg::kslot_n; i++)
        slot[i] <= ucpd_line_pkg::k_code_e'('0);
    end
    else if (rx_idle_en)
    begin
      for (int i = 0; i < ucpd_rx_pkg::kslot_n; i++)
        slot[i] <= ucpd_line_pkg::k_code_e'('0);
    end
    else if (kslot_wr)
      slot[kslot_idx] <= sym.kcode;
  end

  // ---------------------------------------------------------------------
  // stage 1, pattern match and slot check
  // ---------------------------------------------------------------------
  always_ff @(posedge ucpd_clk)
  begin
    if (ordset_eval)
    begin
      for (int i = 0; i < ucpd_rx_pkg::kslot_n; i++)
        good_q[i] <= is_kcode(slot[i]);
      m_sop    <= match3(ucpd_line_pkg::k_sync_1, ucpd_line_pkg::k_sync_1,
                         ucpd_line_pkg::k_sync_1, ucpd_line_pkg::k_sync_2);
      m_sop_p  <= match3(ucpd_line_pkg::k_sync_1, ucpd_line_pkg::k_sync_1,
                         ucpd_line_pkg::k_sync_3, ucpd_line_pkg::k_sync_3);
      m_sop_pp <= match3(ucpd_line_pkg::k_sync_1, ucpd_line_pkg::k_sync_3,
                         ucpd_line_pkg::k_sync_1, ucpd_line_pkg::k_sync_3);
      m_hrst   <= match3(ucpd_line_pkg::k_rst_1, ucpd_line_pkg::k_rst_1,
                         ucpd_line_pkg::k_rst_1, ucpd_line_pkg::k_rst_2);
      m_crst   <= match3(ucpd_line_pkg::k_rst_1, ucpd_line_pkg::k_sync_1,
                         ucpd_line_pkg::k_rst_1, ucpd_line_pkg::k_sync_3);
    end
  end

  assign os_hit = m_sop | m_sop_p | m_sop_pp | m_crst;

  always_comb
  begin
    case (good_q)
      4'b1111: kerr_nxt = 3'd0;  // clean set
      4'b1110: kerr_nxt = 3'd1;  // first k-code bad
      4'b1101: kerr_nxt = 3'd2;
      4'b1011: kerr_nxt = 3'd3;
      4'b0111: kerr_nxt = 3'd4;
      default: kerr_nxt = 3'd7;  // two or more bad
    endcase
    if (m_sop)
      det_nxt = ucpd_rx_pkg::sop;
    else if (m_sop_p)
      det_nxt = ucpd_rx_pkg::sop_p;
    else if (m_sop_pp)
      det_nxt = ucpd_rx_pkg::sop_pp;
    else
      det_nxt = ucpd_rx_pkg::cable_rst;
  end

  // ---------------------------------------------------------------------
  // stage 2, report
  // ---------------------------------------------------------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n)
  begin
    if (!ic_rst_n)
    begin
      eval_d     <= 1'b0;
      rx_ordset  <= '0;
      ordset_vld <= 1'b0;
      hrst_det   <= 1'b0;
    end
    else
    begin
      eval_d     <= ordset_eval & ~rx_idle_en;
      ordset_vld <= eval_d & ~m_hrst & os_hit;
      hrst_det   <= eval_d & m_hrst;  // hard reset always enabled
      if (eval_d)
      begin
        rx_ordset.kerr_num      <= kerr_nxt;
        rx_ordset.three_of_four <= (kerr_nxt != 3'd0) && (kerr_nxt != 3'd7);
        if (!m_hrst && os_hit)
          rx_ordset.det <= det_nxt;
      end
    end
  end

endmodule

/* logic/nibble_decoder.sv */
`timescale 1ns/10ps

module nibble_decoder (
  input  logic                ucpd_clk,
  input  logic                ic_rst_n,
  input  logic                rx_idle_en,
  input  ucpd_line_pkg::sym_u sym,
  input  logic                nib_wr,
  input  logic                nib_hi,
  output logic [7:0]          rx_byte,
  output logic                byte_vld   // rx_byte just assembled
);

  logic [3:0] nib;   // decoded data nibble
  logic [3:0] lo_q;  // first nibble of the byte

  // 4b5b data table, unknown codes give zero
  always_comb
  begin
    case (sym.raw)
      5'b11110: nib = 4'h0;
      5'b01001: nib = 4'h1;
      5'b10100: nib = 4'h2;
      5'b10101: nib = 4'h3;
      5'b01010: nib = 4'h4;
      5'b01011: nib = 4'h5;
      5'b01110: nib = 4'h6;
      5'b01111: nib = 4'h7;
      5'b10010: nib = 4'h8;
      5'b10011: nib = 4'h9;
      5'b10110: nib = 4'ha;
      5'b10111: nib = 4'hb;
      5'b11010: nib = 4'hc;
      5'b11011: nib = 4'hd;
      5'b11100: nib = 4'he;
      5'b11101: nib = 4'hf;
      default:  nib = 4'h0;
    endcase
  end

  always_ff @(posedge ucpd_clk or negedge ic_rst_n)
  begin
    if (!ic_rst_n)
    begin
      lo_q     <= 4'h0;
      byte_vld <= 1'b0;
    end
    else if (rx_idle_en)
    begin
      lo_q     <= 4'h0;
      byte_vld <= 1'b0;
    end
    else
    begin
      byte_vld <= nib_wr & nib_hi;
      if (nib_wr && !nib_hi)
        lo_q <= nib;
    end
  end

  always_ff @(posedge ucpd_clk)
  begin
    if (nib_wr && nib_hi)
      rx_byte <= {nib, lo_q};  // high nibble arrives second
  end

endmodule

/* logic/rx_data_reg.sv */
`timescale 1ns/10ps

module rx_data_reg (
  input  logic                              ucpd_clk,
  input  logic                              ic_rst_n,
  input  logic                              rx_idle_en,
  input  logic                              sop_start,   // new packet, clear count
  input  logic [7:0]                        rx_byte,
  input  logic                              byte_vld,
  input  logic                              rxdr_rd,
  output logic [7:0]                        rxdr,
  output logic                              rxne,
  output logic                              ovrflow,
  output logic [ucpd_rx_pkg::paysize_w-1:0] rx_paysize
);

  logic ovr_nxt;  // byte arrives with rxdr still unread
  logic accept;   // byte goes into rxdr

  assign ovr_nxt = byte_vld & rxne & ~rxdr_rd & ~rx_idle_en;
  assign accept  = byte_vld & ~rx_idle_en & (~rxne | rxdr_rd);

  always_ff @(posedge ucpd_clk or negedge ic_rst_n)
  begin
    if (!ic_rst_n)
    begin
      rxne       <= 1'b0;
      ovrflow    <= 1'b0;
      rx_paysize <= '0;
    end
    else
    begin
      ovrflow <= ovr_nxt;  // new byte dropped
      if (rx_idle_en)
        rxne <= 1'b0;
      else if (accept)
        rxne <= 1'b1;
      else if (rxdr_rd)
        rxne <= 1'b0;
      if (sop_start)
        rx_paysize <= '0;
      else if (byte_vld)
        rx_paysize <= rx_paysize + 1'b1;  // counts dropped bytes too
    end
  end

  // old byte kept on overflow
  always_ff @(posedge ucpd_clk)
  begin
    if (accept)
      rxdr <= rx_byte;
  end

endmodule

/* logic/ucpd_rx_top.sv */
`timescale 1ns/10ps

module ucpd_rx_top (
  input  logic                                 ucpd_clk,
  input  logic                                 ic_rst_n,
  input  logic                                 rx_bit_sample,  // one strobe per line bit
  input  logic                                 decode_bmc,     // bmc decoded bit
  input  logic                                 rx_idle_en,
  input  logic                                 rx_sop_en,
  input  logic                                 rx_data_en,
  input  logic                                 rxdr_rd,        // rxdr read pulse
  output ucpd_rx_pkg::rx_status_t              rx_status,
  output ucpd_rx_pkg::ordset_info_t            rx_ordset,
  output logic [7:0]                           rxdr,
  output logic [ucpd_rx_pkg::paysize_w-1:0]    rx_paysize
);

  ucpd_line_pkg::sym_u sym;  // last complete symbol
  logic                sym_vld;
  logic                kslot_wr;
  logic [1:0]          kslot_idx;
  logic                ordset_eval;
  logic                nib_wr;
  logic                nib_hi;
  logic                sop_start;
  logic                msg_end;
  logic                ordset_vld;
  logic                hrst_det;
  logic [7:0]          rx_byte;
  logic                byte_vld;
  logic                rxne;
  logic                ovrflow;

  // ---------------------------------------------------------------------
  // status word
  // ---------------------------------------------------------------------
  assign rx_status = '{
    msg_end    : msg_end,
    ovrflow    : ovrflow,
    hrst_det   : hrst_det,
    ordset_vld : ordset_vld,
    rxne       : rxne
  };

  rx_phase_ctrl u_ctrl (
    .ucpd_clk    (ucpd_clk),
    .ic_rst_n    (ic_rst_n),
    .rx_idle_en  (rx_idle_en),
    .rx_sop_en   (rx_sop_en),
    .rx_data_en  (rx_data_en),
    .sym         (sym),
    .sym_vld     (sym_vld),
    .kslot_wr    (kslot_wr),
    .kslot_idx   (kslot_idx),
    .ordset_eval (ordset_eval),
    .nib_wr      (nib_wr),
    .nib_hi      (nib_hi),
    .sop_start   (sop_start),
    .msg_end     (msg_end)
  );

  symbol_shifter u_shift (
    .ucpd_clk      (ucpd_clk),
    .ic_rst_n      (ic_rst_n),
    .rx_idle_en    (rx_idle_en),
    .rx_sop_en     (rx_sop_en),
    .rx_data_en    (rx_data_en),
    .rx_bit_sample (rx_bit_sample),
    .decode_bmc    (decode_bmc),
    .sym           (sym),
    .sym_vld       (sym_vld)
  );

  ordset_detector u_ordset (
    .ucpd_clk    (ucpd_clk),
    .ic_rst_n    (ic_rst_n),
    .rx_idle_en  (rx_idle_en),
    .sym         (sym),
    .kslot_wr    (kslot_wr),
    .kslot_idx   (kslot_idx),
    .ordset_eval (ordset_eval),
    .rx_ordset   (rx_ordset),
    .ordset_vld  (ordset_vld),
    .hrst_det    (hrst_det)
  );

  nibble_decoder u_nib (
    .ucpd_clk   (ucpd_clk),
    .ic_rst_n   (ic_rst_n),
    .rx_idle_en (rx_idle_en),
    .sym        (sym),
    .nib_wr     (nib_wr),
    .nib_hi     (nib_hi),
    .rx_byte    (rx_byte),
    .byte_vld   (byte_vld)
  );

  rx_data_reg u_rxdr (
    .ucpd_clk   (ucpd_clk),
    .ic_rst_n   (ic_rst_n),
    .rx_idle_en (rx_idle_en),
    .sop_start  (sop_start),
    .rx_byte    (rx_byte),
    .byte_vld   (byte_vld),
    .rxdr_rd    (rxdr_rd),
    .rxdr       (rxdr),
    .rxne       (rxne),
    .ovrflow    (ovrflow),
    .rx_paysize (rx_paysize)
  );

endmodule

/* verification/ucpd_rx_assert.sv */
`timescale 1ns/10ps

module ucpd_rx_assert (
  input logic                    ucpd_clk,
  input logic                    ic_rst_n,
  input ucpd_rx_pkg::rx_status_t rx_status
);

  // ---------------------------------------------------------------------
  // status pulse rules
  // ---------------------------------------------------------------------
  a_set_excl: assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    !(rx_status.ordset_vld && rx_status.hrst_det))  // hard reset never reported as set
    else $error("ordset_vld and hrst_det high in the same cycle");

  a_ovr_rxne: assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    rx_status.ovrflow |-> rx_status.rxne)  // only a full rxdr can overflow
    else $error("ovrflow high while rxne is low");

  a_vld_one: assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    rx_status.ordset_vld |=> !rx_status.ordset_vld)
    else $error("ordset_vld longer than one cycle");

  a_hrst_one: assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    rx_status.hrst_det |=> !rx_status.hrst_det)
    else $error("hrst_det longer than one cycle");

  a_msg_one: assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    rx_status.msg_end |=> !rx_status.msg_end)
    else $error("msg_end longer than one cycle");

  a_ovr_one: assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    rx_status.ovrflow |=> !rx_status.ovrflow)
    else $error("ovrflow longer than one cycle");

  a_rst_low: assert property (@(posedge ucpd_clk)
    !ic_rst_n |-> (rx_status == ucpd_rx_pkg::rx_status_t'('0)))  // all quiet in reset
    else $error("status bit high during reset");

endmodule

bind ucpd_rx_top ucpd_rx_assert u_assert (
  .ucpd_clk  (ucpd_clk),
  .ic_rst_n  (ic_rst_n),
  .rx_status (rx_status)
);

/* verification/ucpd_rx_tb.sv */
`timescale 1ns/10ps

module ucpd_rx_tb;

  localparam int         n_rows = 10;
  localparam logic [4:0] s1     = ucpd_line_pkg::sync_1;
  localparam logic [4:0] s2     = ucpd_line_pkg::sync_2;
  localparam logic [4:0] s3     = ucpd_line_pkg::sync_3;
  localparam logic [4:0] r1     = ucpd_line_pkg::rst_1;
  localparam logic [4:0] r2     = ucpd_line_pkg::rst_2;
  localparam logic [4:0] bad_k  = 5'b01010;  // data code 4, not a k-code

  typedef struct packed {
    logic [3:0][ucpd_line_pkg::sym_w-1:0] kc;       // kc[0] goes out first
    logic [7:0]                           nbytes;   // payload bytes, 0 skips data phase
    logic                                 rd_each;  // read rxdr after every byte
    ucpd_rx_pkg::ordset_info_t            exp;      // ordered-set report after sop
    logic                                 hrst;     // hard reset expected
  } row_t;

  logic                              ucpd_clk;
  logic                              ic_rst_n;
  logic                              rx_bit_sample;
  logic                              decode_bmc;
  logic                              rx_idle_en;
  logic                              rx_sop_en;
  logic                              rx_data_en;
  logic                              rxdr_rd;
  ucpd_rx_pkg::rx_status_t           rx_status;
  ucpd_rx_pkg::ordset_info_t         rx_ordset;
  logic [7:0]                        rxdr;
  logic [ucpd_rx_pkg::paysize_w-1:0] rx_paysize;

  row_t        rows [n_rows];
  logic [31:0] lcg_state   = 32'd40;  // payload generator
  int          mism_cnt    = 0;       // wrong values
  int          fail_cnt    = 0;       // missing handshakes
  int          vld_cnt     = 0;       // status pulses seen so far
  int          hrst_cnt    = 0;
  int          msg_cnt     = 0;
  int          ovr_cnt     = 0;
  int          cycle_cnt   = 0;
  int          cycle_limit = 200;

  ucpd_rx_top UUT (
    .ucpd_clk      (ucpd_clk),
    .ic_rst_n      (ic_rst_n),
    .rx_bit_sample (rx_bit_sample),
    .decode_bmc    (decode_bmc),
    .rx_idle_en    (rx_idle_en),
    .rx_sop_en     (rx_sop_en),
    .rx_data_en    (rx_data_en),
    .rxdr_rd       (rxdr_rd),
    .rx_status     (rx_status),
    .rx_ordset     (rx_ordset),
    .rxdr          (rxdr),
    .rx_paysize    (rx_paysize)
  );

  always #50 ucpd_clk = ~ucpd_clk;  // 100 ns period

  // pulses counted from the values held just before each rising edge
  always @(posedge ucpd_clk)
  begin
    if (ic_rst_n)
    begin
      vld_cnt  += int'(rx_status.ordset_vld);
      hrst_cnt += int'(rx_status.hrst_det);
      msg_cnt  += int'(rx_status.msg_end);
      ovr_cnt  += int'(rx_status.ovrflow);
    end
  end

  always @(posedge ucpd_clk)
  begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit)
    begin
      $display("timeout, run did not finish within %0d cycles", cycle_limit);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // ---------------------------------------------------------------------
  // stimulus helpers
  // ---------------------------------------------------------------------
  function automatic row_t make_row(input logic [4:0] k0, input logic [4:0] k1,
                                    input logic [4:0] k2, input logic [4:0] k3,
                                    input int nb, input logic rd,
                                    input ucpd_rx_pkg::ordset_e det, input logic tof,
                                    input logic [2:0] kerr, input logic hrst);
    row_t r;
    r.kc      = {k3, k2, k1, k0};
    r.nbytes  = 8'(nb);
    r.rd_each = rd;
    r.exp     = '{kerr_num: kerr, three_of_four: tof, det: det};
    r.hrst    = hrst;
    return r;
  endfunction

  function automatic int row_bits(input row_t r);
    return 20 + ((r.nbytes != 8'd0) ? int'(r.nbytes) * 10 + 5 : 0);  // k-codes, data, eop
  endfunction

  function automatic logic [7:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  function automatic logic [4:0] encode_nibble(input logic [3:0] n);
    case (n)
      4'h0: return 5'b11110;
      4'h1: return 5'b01001;
      4'h2: return 5'b10100;
      4'h3: return 5'b10101;
      4'h4: return 5'b01010;
      4'h5: return 5'b01011;
      4'h6: return 5'b01110;
      4'h7: return 5'b01111;
      4'h8: return 5'b10010;
      4'h9: return 5'b10011;
      4'ha: return 5'b10110;
      4'hb: return 5'b10111;
      4'hc: return 5'b11010;
      4'hd: return 5'b11011;
      4'he: return 5'b11100;
      default: return 5'b11101;
    endcase
  endfunction

  task automatic send_bit(input logic b);
    rx_bit_sample = 1'b1;  // one strobe every fourth cycle
    decode_bmc    = b;
    @(negedge ucpd_clk);
    rx_bit_sample = 1'b0;
    repeat (3) @(negedge ucpd_clk);
  endtask

  task automatic send_symbol(input logic [4:0] code);
    for (int i = 0; i < ucpd_line_pkg::sym_w; i++)
      send_bit(code[i]);  // lsb first on the line
  endtask

  // ---------------------------------------------------------------------
  // compare tasks
  // ---------------------------------------------------------------------
  task automatic check_ordset(input ucpd_rx_pkg::ordset_info_t got,
                              input ucpd_rx_pkg::ordset_info_t exp, input string what);
    if (got !== exp)
    begin
      $display("mismatch at %0t: %s got det %0d 3of4 %0b kerr %0d, expected %0d %0b %0d",
               $time, what, got.det, got.three_of_four, got.kerr_num,
               exp.det, exp.three_of_four, exp.kerr_num);
      mism_cnt++;
    end
  endtask

  task automatic check_status(input ucpd_rx_pkg::rx_status_t got,
                              input ucpd_rx_pkg::rx_status_t exp, input string what);
    if (got !== exp)
    begin
      $display("mismatch at %0t: %s got %b expected %b (msg_end ovr hrst vld rxne)",
               $time, what, got, exp);
      mism_cnt++;
    end
  endtask

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp)
    begin
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      mism_cnt++;
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp)
    begin
      $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
      mism_cnt++;
    end
  endtask

  task automatic read_byte(input logic [7:0] exp);
    int i;
    i = 0;
    while (!rx_status.rxne && i < 8)
    begin
      @(negedge ucpd_clk);
      i++;
    end
    if (!rx_status.rxne)
    begin
      $display("rxne did not rise within 8 cycles after a received byte");
      fail_cnt++;
    end
    else
      check_byte(rxdr, exp, "rxdr read");
    rxdr_rd = 1'b1;  // one-cycle read pulse
    @(negedge ucpd_clk);
    rxdr_rd = 1'b0;
  endtask

  // ---------------------------------------------------------------------
  // one message: idle, ordered set, optional payload and eop
  // ---------------------------------------------------------------------
  task automatic run_row(input row_t r);
    int                      vld0;
    int                      hrst0;
    int                      msg0;
    int                      ovr0;
    logic [7:0]              b;
    logic [7:0]              first_b;
    ucpd_rx_pkg::rx_status_t exp_st;
    rx_idle_en = 1'b1;
    repeat (2) @(negedge ucpd_clk);
    rx_idle_en = 1'b0;
    check_status(rx_status, '0, "status after idle");  // rxne cleared by idle
    vld0  = vld_cnt;
    hrst0 = hrst_cnt;
    msg0  = msg_cnt;
    ovr0  = ovr_cnt;
    rx_sop_en = 1'b1;
    for (int s = 0; s < ucpd_rx_pkg::kslot_n; s++)
      send_symbol(r.kc[s]);
    for (int i = 0; i < 8; i++)
    begin
      if (vld_cnt != vld0 || hrst_cnt != hrst0)
        break;  // report is out
      @(negedge ucpd_clk);
    end
    rx_sop_en = 1'b0;
    check_ordset(rx_ordset, r.exp, "ordered set");
    check_count(vld_cnt - vld0, (!r.hrst && r.exp.kerr_num != 3'd7) ? 1 : 0, "ordset_vld");
    check_count(hrst_cnt - hrst0, r.hrst ? 1 : 0, "hrst_det");
    check_count(int'(rx_paysize), 0, "payload count after sop");
    if (r.nbytes != 8'd0)
    begin
      rx_data_en = 1'b1;
      first_b    = 8'h00;
      for (int k = 0; k < int'(r.nbytes); k++)
      begin
        b = next_rand();
        if (k == 0)
          first_b = b;
        send_symbol(encode_nibble(b[3:0]));  // low nibble first
        send_symbol(encode_nibble(b[7:4]));
        if (r.rd_each)
          read_byte(b);
      end
      send_symbol(ucpd_line_pkg::eop_k);
      for (int i = 0; i < 8 && msg_cnt == msg0; i++)
        @(negedge ucpd_clk);
      if (msg_cnt == msg0)
      begin
        $display("msg_end did not pulse within 8 cycles after eop");
        fail_cnt++;
      end
      rx_data_en = 1'b0;
      check_count(msg_cnt - msg0, 1, "msg_end");
      check_count(int'(rx_paysize), int'(r.nbytes), "payload count");
      check_count(ovr_cnt - ovr0, r.rd_each ? 0 : int'(r.nbytes) - 1, "ovrflow");
      if (!r.rd_each)
        check_byte(rxdr, first_b, "rxdr kept after overflow");
      exp_st      = '0;
      exp_st.rxne = ~r.rd_each;
      check_status(rx_status, exp_st, "status after eop");
    end
  endtask

  initial
  begin
    ucpd_clk      = 1'b0;
    ic_rst_n      = 1'b0;
    rx_bit_sample = 1'b0;
    decode_bmc    = 1'b0;
    rx_idle_en    = 1'b0;
    rx_sop_en     = 1'b0;
    rx_data_en    = 1'b0;
    rxdr_rd       = 1'b0;
    // k0..k3, bytes, read each, det, 3of4, kerr, hard reset
    rows[0] = make_row(s1, s1, s1, s2, 4, 1'b1, ucpd_rx_pkg::sop, 1'b0, 3'd0, 1'b0);
    rows[1] = make_row(s1, s1, s3, s3, 3, 1'b1, ucpd_rx_pkg::sop_p, 1'b0, 3'd0, 1'b0);
    rows[2] = make_row(s1, s3, s1, s3, 2, 1'b1, ucpd_rx_pkg::sop_pp, 1'b0, 3'd0, 1'b0);
    rows[3] = make_row(r1, s1, r1, s3, 2, 1'b1, ucpd_rx_pkg::cable_rst, 1'b0, 3'd0, 1'b0);
    rows[4] = make_row(s1, s1, bad_k, s3, 2, 1'b1, ucpd_rx_pkg::sop_p, 1'b1, 3'd3, 1'b0);
    rows[5] = make_row(bad_k, s1, r1, s3, 1, 1'b1, ucpd_rx_pkg::cable_rst, 1'b1, 3'd1, 1'b0);
    rows[6] = make_row(s1, bad_k, bad_k, s2, 0, 1'b1, ucpd_rx_pkg::cable_rst, 1'b0, 3'd7, 1'b0);
    rows[7] = make_row(r1, r1, r1, r2, 0, 1'b1, ucpd_rx_pkg::cable_rst, 1'b0, 3'd0, 1'b1);
    rows[8] = make_row(s1, s1, s1, s2, 3, 1'b0, ucpd_rx_pkg::sop, 1'b0, 3'd0, 1'b0);
    rows[9] = make_row(s1, s1, s3, s3, 2, 1'b1, ucpd_rx_pkg::sop_p, 1'b0, 3'd0, 1'b0);
    for (int i = 0; i < n_rows; i++)
      cycle_limit += 4 * row_bits(rows[i]);  // four cycles per line bit
    repeat (3) @(negedge ucpd_clk);
    ic_rst_n = 1'b1;
    check_status(rx_status, '0, "status after reset");
    check_ordset(rx_ordset, '0, "ordered set after reset");
    check_count(int'(rx_paysize), 0, "payload count after reset");
    for (int i = 0; i < n_rows; i++)
      run_row(rows[i]);
    $display("errors: %0d mismatches, %0d missing handshakes", mism_cnt, fail_cnt);
    if (mism_cnt == 0 && fail_cnt == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* all.f */
logic/ucpd_line_pkg.sv
logic/ucpd_rx_pkg.sv
logic/symbol_shifter.sv
logic/rx_phase_ctrl.sv
logic/ordset_detector.sv
logic/nibble_decoder.sv
logic/rx_data_reg.sv
logic/ucpd_rx_top.sv
verification/ucpd_rx_assert.sv
verification/ucpd_rx_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the ucpd receive testbench with verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module ucpd_rx_tb -f all.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vucpd_rx_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" "$log"; then
  exit 1
fi
if ! grep -q "RESULT: PASS" "$log"; then
  echo "no result line found in $log"
  exit 1
fi
exit 0
